/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mp4_control
RTL_TOP   ?= mp4_control
FLIST     ?= compile.f
BUILD     ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FLIST) *.sv *.svh
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FLIST) \
		--top-module $(TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* compile.f */
+incdir+.
rv32i_ctrl_pkg.sv
cw_if.sv
cw_decoder.sv
cw_pipe.sv
stage_load_ctrl.sv
mp4_control.sv
tb_mp4_control.sv

/* ctrl_params.svh */
// ================================================
// control unit parameters: instruction width,
// register address width and field positions
// ================================================
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// instruction and register file sizes
`define CTRL_XLEN        32
`define CTRL_REG_ADDR_W  5

// rv32i field positions
`define CTRL_OPCODE_LSB  0
`define CTRL_OPCODE_MSB  6
`define CTRL_RD_LSB      7
`define CTRL_RD_MSB      11
`define CTRL_FUNCT3_LSB  12
`define CTRL_FUNCT3_MSB  14
`define CTRL_FUNCT7_LSB  25
`define CTRL_FUNCT7_MSB  31

`endif

/* cw_decoder.sv */
// ================================================
// decode stage: instruction register and opcode
// to execute/memory/writeback control word decode
// ================================================
`include "ctrl_params.svh"

module cw_decoder
    import rv32i_ctrl_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  rst,
    input  logic [`CTRL_XLEN-1:0] i_instr,
    input  logic                  i_fetch_valid,
    input  logic                  i_if_de_ld,
    cw_if.src                     o_cw
);

    logic [`CTRL_XLEN-1:0]                        instr_q;
    logic                                         valid_q;
    opcode_t                                      opcode;
    logic [`CTRL_FUNCT3_MSB-`CTRL_FUNCT3_LSB:0]   funct3;
    logic [`CTRL_FUNCT7_MSB-`CTRL_FUNCT7_LSB:0]   funct7;
    reg_addr_t                                    rd;
    logic                                         is_reg;
    cw_exe_t                                      exe_w;
    cw_mem_t                                      mem_w;
    cw_wb_t                                       wb_w;

    // decode register valid
    always_ff @(posedge i_clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (i_if_de_ld) begin
            valid_q <= i_fetch_valid;
        end
    end

    // instruction payload, loaded with the valid
    always_ff @(posedge i_clk) begin
        if (i_if_de_ld) begin
            instr_q <= i_instr;
        end
    end

    // field split
    assign opcode = opcode_t'(instr_q[`CTRL_OPCODE_MSB:`CTRL_OPCODE_LSB]);
    assign funct3 = instr_q[`CTRL_FUNCT3_MSB:`CTRL_FUNCT3_LSB];
    assign funct7 = instr_q[`CTRL_FUNCT7_MSB:`CTRL_FUNCT7_LSB];
    assign rd     = instr_q[`CTRL_RD_MSB:`CTRL_RD_LSB];
    assign is_reg = (opcode == op_reg);

    always_comb begin
        // defaults, also the no-op word
        exe_w.aluop     = alu_add;
        exe_w.alu1      = alu1_rs1;
        exe_w.alu2      = alu2_i_imm;
        exe_w.cmpop     = cmp_beq;
        exe_w.cmp       = cmp_rs2;
        mem_w.mem_read  = 1'b0;
        mem_w.mem_write = 1'b0;
        wb_w.ld_reg     = 1'b0;
        wb_w.rf         = rf_alu;
        wb_w.rd         = '0;

        case (opcode)
            op_lui: begin
                // immediate straight to rd
                wb_w.ld_reg = 1'b1;
                wb_w.rf     = rf_u_imm;
                wb_w.rd     = rd;
            end
            op_auipc: begin
                exe_w.alu1  = alu1_pc;
                exe_w.alu2  = alu2_u_imm;
                wb_w.ld_reg = 1'b1;
                wb_w.rd     = rd;
            end
            op_jal: begin
                // target from alu, link value pc+4
                exe_w.alu1  = alu1_pc;
                exe_w.alu2  = alu2_j_imm;
                wb_w.ld_reg = 1'b1;
                wb_w.rf     = rf_pc_plus4;
                wb_w.rd     = rd;
            end
            op_jalr: begin
                wb_w.ld_reg = 1'b1;
                wb_w.rf     = rf_pc_plus4;
                wb_w.rd     = rd;
            end
            op_br: begin
                // target computed regardless of outcome
                exe_w.alu1 = alu1_pc;
                exe_w.alu2 = alu2_b_imm;
                case (funct3)
                    3'b001:  exe_w.cmpop = cmp_bne;
                    3'b100:  exe_w.cmpop = cmp_blt;
                    3'b101:  exe_w.cmpop = cmp_bge;
                    3'b110:  exe_w.cmpop = cmp_bltu;
                    3'b111:  exe_w.cmpop = cmp_bgeu;
                    default: exe_w.cmpop = cmp_beq;
                endcase
            end
            op_load: begin
                mem_w.mem_read = 1'b1;
                wb_w.ld_reg    = 1'b1;
                wb_w.rd        = rd;
                // width and sign extension
                case (funct3)
                    3'b000:  wb_w.rf = rf_lb;
                    3'b001:  wb_w.rf = rf_lh;
                    3'b010:  wb_w.rf = rf_lw;
                    3'b100:  wb_w.rf = rf_lbu;
                    3'b101:  wb_w.rf = rf_lhu;
                    default: wb_w.rf = rf_alu;
                endcase
            end
            op_store: begin
                exe_w.alu2      = alu2_s_imm;
                mem_w.mem_write = 1'b1;
            end
            op_imm, op_reg: begin
                wb_w.ld_reg = 1'b1;
                wb_w.rd     = rd;
                if (is_reg) begin
                    exe_w.alu2 = alu2_rs2;
                end
                case (funct3)
                    3'b000:  exe_w.aluop = (is_reg && funct7[5]) ? alu_sub : alu_add;
                    3'b001:  exe_w.aluop = alu_sll;
                    3'b010: begin
                        // slt through the comparator
                        exe_w.cmpop = cmp_blt;
                        exe_w.cmp   = is_reg ? cmp_rs2 : cmp_i_imm;
                        wb_w.rf     = rf_br_en;
                    end
                    3'b011: begin
                        exe_w.cmpop = cmp_bltu;
                        exe_w.cmp   = is_reg ? cmp_rs2 : cmp_i_imm;
                        wb_w.rf     = rf_br_en;
                    end
                    3'b100:  exe_w.aluop = alu_xor;
                    3'b101:  exe_w.aluop = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  exe_w.aluop = alu_or;
                    default: exe_w.aluop = alu_and;
                endcase
            end
            default: ;
        endcase
    end

    assign o_cw.exe   = exe_w;
    assign o_cw.mem   = mem_w;
    assign o_cw.wb    = wb_w;
    assign o_cw.valid = valid_q;

    // downstream stall must also freeze decode
    a_de_hold: assert property (@(posedge i_clk) disable iff (rst)
        !o_cw.ld && valid_q |=> valid_q && $stable(instr_q));

endmodule

/* cw_if.sv */
// ================================================
// decoded control word link, decode to execute
// ================================================
interface cw_if
    import rv32i_ctrl_pkg::*;
();

    // per-stage parts of the word
    cw_exe_t exe;
    cw_mem_t mem;
    cw_wb_t  wb;

    // word holds a real instruction
    logic    valid;
    // decode to execute load, from the pipe side
    logic    ld;

    modport src (
        output exe,
        output mem,
        output wb,
        output valid,
        input  ld
    );

    modport dst (
        input  exe,
        input  mem,
        input  wb,
        input  valid,
        output ld
    );

endinterface

/* cw_pipe.sv */
// ================================================
// execute, memory and writeback control word slots
// with valid tracking and bubble insertion
// ================================================
module cw_pipe
    import rv32i_ctrl_pkg::*;
(
    input  logic    i_clk,
    input  logic    rst,
    cw_if.dst       i_cw,
    input  logic    i_exe_mem_ld,
    input  logic    i_mem_wb_ld,
    input  logic    i_de_exe_ld,
    input  logic    i_exe_rdy,
    input  logic    i_mem_rdy,
    output cw_exe_t o_exe,
    output cw_mem_t o_mem,
    output cw_wb_t  o_wb,
    output logic    o_exe_valid,
    output logic    o_mem_valid,
    output logic    o_wb_valid
);

    // execute slot keeps the whole word
    cw_exe_t exe_exe_q;
    cw_mem_t exe_mem_q;
    cw_wb_t  exe_wb_q;
    // memory slot drops the execute part
    cw_mem_t mem_mem_q;
    cw_wb_t  mem_wb_q;
    cw_wb_t  wb_wb_q;
    logic    exe_valid_q;
    logic    mem_valid_q;
    logic    wb_valid_q;

    assign i_cw.ld = i_de_exe_ld;

    // a stalled upstream stage hands on a bubble
    always_ff @(posedge i_clk) begin
        if (rst) begin
            exe_valid_q <= 1'b0;
            mem_valid_q <= 1'b0;
            wb_valid_q  <= 1'b0;
        end else begin
            // decode is always ready
            if (i_de_exe_ld) begin
                exe_valid_q <= i_cw.valid;
            end
            if (i_exe_mem_ld) begin
                mem_valid_q <= exe_valid_q && i_exe_rdy;
            end
            if (i_mem_wb_ld) begin
                wb_valid_q <= mem_valid_q && i_mem_rdy;
            end
        end
    end

    // word payloads
    always_ff @(posedge i_clk) begin
        if (i_de_exe_ld) begin
            exe_exe_q <= i_cw.exe;
            exe_mem_q <= i_cw.mem;
            exe_wb_q  <= i_cw.wb;
        end
        if (i_exe_mem_ld) begin
            mem_mem_q <= exe_mem_q;
            mem_wb_q  <= exe_wb_q;
        end
        if (i_mem_wb_ld) begin
            wb_wb_q <= mem_wb_q;
        end
    end

    assign o_exe       = exe_exe_q;
    assign o_mem       = mem_mem_q;
    assign o_wb        = wb_wb_q;
    assign o_exe_valid = exe_valid_q;
    assign o_mem_valid = mem_valid_q;
    assign o_wb_valid  = wb_valid_q;

    // busy stage keeps its word until it reports ready
    a_exe_hold: assert property (@(posedge i_clk) disable iff (rst)
        exe_valid_q && !i_exe_rdy |=> exe_valid_q && $stable(exe_exe_q));

    a_mem_hold: assert property (@(posedge i_clk) disable iff (rst)
        mem_valid_q && !i_mem_rdy |=> mem_valid_q && $stable(mem_mem_q)
            && $stable(mem_wb_q));

endmodule

/* mp4_control.sv */
// ================================================
// rv32i pipeline control unit: decode, word pipe
// and stall control
// ================================================
`include "ctrl_params.svh"

module mp4_control
    import rv32i_ctrl_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  rst,
    input  logic [`CTRL_XLEN-1:0] i_instr,
    input  logic                  i_fetch_valid,
    input  logic                  i_exe_rdy,
    input  logic                  i_mem_rdy,
    input  logic                  i_wb_rdy,
    output logic                  o_if_de_ld,
    output logic                  o_de_exe_ld,
    output logic                  o_exe_mem_ld,
    output logic                  o_mem_wb_ld,
    output logic                  o_imem_read,
    output logic                  o_load_pc,
    output alu_ops_t              o_exe_aluop,
    output alu1_sel_t             o_exe_alu1_sel,
    output alu2_sel_t             o_exe_alu2_sel,
    output cmp_ops_t              o_exe_cmpop,
    output cmp_sel_t              o_exe_cmp_sel,
    output logic                  o_exe_valid,
    output logic                  o_mem_read,
    output logic                  o_mem_write,
    output logic                  o_mem_valid,
    output logic                  o_wb_ld_reg,
    output rf_sel_t               o_wb_rf_sel,
    output reg_addr_t             o_wb_rd,
    output logic                  o_wb_valid
);

    cw_exe_t exe_cw;
    cw_mem_t mem_cw;
    cw_wb_t  wb_cw;

    // decode to execute word link
    cw_if cw0 ();

    cw_decoder dec0 (
        .i_clk         (i_clk),
        .rst           (rst),
        .i_instr       (i_instr),
        .i_fetch_valid (i_fetch_valid),
        .i_if_de_ld    (o_if_de_ld),
        .o_cw          (cw0.src)
    );

    cw_pipe pipe0 (
        .i_clk        (i_clk),
        .rst          (rst),
        .i_cw         (cw0.dst),
        .i_exe_mem_ld (o_exe_mem_ld),
        .i_mem_wb_ld  (o_mem_wb_ld),
        .i_de_exe_ld  (o_de_exe_ld),
        .i_exe_rdy    (i_exe_rdy),
        .i_mem_rdy    (i_mem_rdy),
        .o_exe        (exe_cw),
        .o_mem        (mem_cw),
        .o_wb         (wb_cw),
        .o_exe_valid  (o_exe_valid),
        .o_mem_valid  (o_mem_valid),
        .o_wb_valid   (o_wb_valid)
    );

    stage_load_ctrl ldc0 (
        .rst          (rst),
        .i_exe_valid  (o_exe_valid),
        .i_mem_valid  (o_mem_valid),
        .i_wb_valid   (o_wb_valid),
        .i_exe_rdy    (i_exe_rdy),
        .i_mem_rdy    (i_mem_rdy),
        .i_wb_rdy     (i_wb_rdy),
        .o_if_de_ld   (o_if_de_ld),
        .o_de_exe_ld  (o_de_exe_ld),
        .o_exe_mem_ld (o_exe_mem_ld),
        .o_mem_wb_ld  (o_mem_wb_ld),
        .o_imem_read  (o_imem_read),
        .o_load_pc    (o_load_pc)
    );

    // flatten control words onto plain ports
    assign o_exe_aluop    = exe_cw.aluop;
    assign o_exe_alu1_sel = exe_cw.alu1;
    assign o_exe_alu2_sel = exe_cw.alu2;
    assign o_exe_cmpop    = exe_cw.cmpop;
    assign o_exe_cmp_sel  = exe_cw.cmp;
    assign o_mem_read     = mem_cw.mem_read;
    assign o_mem_write    = mem_cw.mem_write;
    assign o_wb_ld_reg    = wb_cw.ld_reg;
    assign o_wb_rf_sel    = wb_cw.rf;
    assign o_wb_rd        = wb_cw.rd;

endmodule

/* rv32i_ctrl_pkg.sv */
// ================================================
// rv32i control types: opcodes, mux selects and
// the per-stage control words
// ================================================
`include "ctrl_params.svh"

package rv32i_ctrl_pkg;

    // the nine base opcodes handled by decode
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops_t;

    // same code points as branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_ops_t;

    typedef enum logic {alu1_rs1, alu1_pc} alu1_sel_t;

    typedef enum logic [2:0] {
        alu2_i_imm, alu2_u_imm, alu2_b_imm, alu2_s_imm, alu2_j_imm, alu2_rs2
    } alu2_sel_t;

    typedef enum logic {cmp_rs2, cmp_i_imm} cmp_sel_t;

    // register file write-back source
    typedef enum logic [3:0] {
        rf_alu, rf_br_en, rf_u_imm, rf_lw, rf_pc_plus4, rf_lb, rf_lbu, rf_lh, rf_lhu
    } rf_sel_t;

    typedef logic [`CTRL_REG_ADDR_W-1:0] reg_addr_t;

    typedef struct packed {
        alu_ops_t  aluop;
        alu1_sel_t alu1;
        alu2_sel_t alu2;
        cmp_ops_t  cmpop;
        cmp_sel_t  cmp;
    } cw_exe_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
    } cw_mem_t;

    typedef struct packed {
        logic      ld_reg;
        rf_sel_t   rf;
        reg_addr_t rd;
    } cw_wb_t;

endpackage

/* stage_load_ctrl.sv */
// ================================================
// stall control: per-stage loads and fetch enables
// ================================================
module stage_load_ctrl (
    input  logic rst,
    input  logic i_exe_valid,
    input  logic i_mem_valid,
    input  logic i_wb_valid,
    input  logic i_exe_rdy,
    input  logic i_mem_rdy,
    input  logic i_wb_rdy,
    output logic o_if_de_ld,
    output logic o_de_exe_ld,
    output logic o_exe_mem_ld,
    output logic o_mem_wb_ld,
    output logic o_imem_read,
    output logic o_load_pc
);

    logic exe_stall;
    logic mem_stall;
    logic wb_stall;

    // valid and still busy
    assign exe_stall = i_exe_valid && !i_exe_rdy;
    assign mem_stall = i_mem_valid && !i_mem_rdy;
    assign wb_stall  = i_wb_valid && !i_wb_rdy;

    // cascade from writeback back to fetch
    assign o_mem_wb_ld  = !rst && !wb_stall;
    assign o_exe_mem_ld = o_mem_wb_ld && !mem_stall;
    assign o_de_exe_ld  = o_exe_mem_ld && !exe_stall;
    // decode never stalls, fetch follows decode
    assign o_if_de_ld   = o_de_exe_ld;
    assign o_imem_read  = o_de_exe_ld;
    assign o_load_pc    = o_de_exe_ld;

endmodule

/* tb_mp4_control.sv */
// ==================================================
// testbench for the rv32i control unit: decode table,
// streaming, stalls and random back-pressure
// ==================================================
`include "ctrl_params.svh"

module tb_mp4_control
    import rv32i_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic                  i_clk;
    logic                  rst;
    logic [`CTRL_XLEN-1:0] i_instr;
    logic                  i_fetch_valid;
    logic                  i_exe_rdy;
    logic                  i_mem_rdy;
    logic                  i_wb_rdy;
    logic                  o_if_de_ld;
    logic                  o_de_exe_ld;
    logic                  o_exe_mem_ld;
    logic                  o_mem_wb_ld;
    logic                  o_imem_read;
    logic                  o_load_pc;
    alu_ops_t              o_exe_aluop;
    alu1_sel_t             o_exe_alu1_sel;
    alu2_sel_t             o_exe_alu2_sel;
    cmp_ops_t              o_exe_cmpop;
    cmp_sel_t              o_exe_cmp_sel;
    logic                  o_exe_valid;
    logic                  o_mem_read;
    logic                  o_mem_write;
    logic                  o_mem_valid;
    logic                  o_wb_ld_reg;
    rf_sel_t               o_wb_rf_sel;
    reg_addr_t             o_wb_rd;
    logic                  o_wb_valid;

    // stimulus table with expected words
    logic [`CTRL_XLEN-1:0] tbl_instr [64];
    cw_exe_t               tbl_exe [64];
    cw_mem_t               tbl_mem [64];
    cw_wb_t                tbl_wb [64];
    int                    n_cases = 0;
    // in-flight model, index and capture cycle
    int                    q_idx [$];
    int                    q_cyc [$];
    int                    cyc = 0;

    mp4_control dut0 (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error: %0d ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // rd field cycles through 1..31, rs fields fixed
    task automatic add_case(input logic [6:0] op, input logic [2:0] f3, input logic [6:0] f7,
                            input alu_ops_t aluop, input alu1_sel_t a1, input alu2_sel_t a2,
                            input cmp_ops_t cop, input cmp_sel_t cs, input bit mr,
                            input bit mw, input bit ld, input rf_sel_t rf);
        logic [4:0] rd;
        rd = 5'((n_cases % 31) + 1);
        tbl_instr[n_cases] = {f7, 5'd7, 5'd6, f3, rd, op};
        tbl_exe[n_cases] = '{aluop, a1, a2, cop, cs};
        tbl_mem[n_cases] = '{mr, mw};
        tbl_wb[n_cases] = '{ld, rf, ld ? rd : 5'd0};
        n_cases++;
    endtask

    task automatic check_loads(input logic exp, input string what);
        check_eq(32'(o_if_de_ld), 32'(exp), {what, " if_de_ld"});
        check_eq(32'(o_de_exe_ld), 32'(exp), {what, " de_exe_ld"});
        check_eq(32'(o_imem_read), 32'(exp), {what, " imem_read"});
        check_eq(32'(o_load_pc), 32'(exp), {what, " load_pc"});
    endtask

    task automatic check_wb(input int i);
        check_eq(32'({o_wb_ld_reg, o_wb_rf_sel, o_wb_rd}), 32'(tbl_wb[i]),
                 $sformatf("wb word %0d", i));
    endtask

    // empty the pipe with all stages ready
    task automatic drain_pipe();
        do begin
            @(negedge i_clk);
            i_fetch_valid = 1'b0;
            i_exe_rdy = 1'b1;
            i_mem_rdy = 1'b1;
            i_wb_rdy = 1'b1;
            #1;
        end while (o_exe_valid || o_mem_valid || o_wb_valid);
    endtask

    task automatic send_one(input int i);
        @(negedge i_clk);
        i_instr = tbl_instr[i];
        i_fetch_valid = 1'b1;
        #1;
        check_eq(32'(o_if_de_ld), 1, "decode load for single send");
        @(negedge i_clk);
        i_fetch_valid = 1'b0;
    endtask

    // readies random or all high, table streamed behind
    task automatic run_stream(input bit rnd, input bit check_lat);
        int idx;
        int done;
        int k;
        int c;
        idx = 0;
        done = 0;
        while (done < n_cases) begin
            @(negedge i_clk);
            i_instr = (idx < n_cases) ? tbl_instr[idx] : '0;
            i_fetch_valid = (idx < n_cases);
            i_exe_rdy = rnd ? ($urandom % 4 != 0) : 1'b1;
            i_mem_rdy = rnd ? ($urandom % 4 != 0) : 1'b1;
            i_wb_rdy = rnd ? ($urandom % 4 != 0) : 1'b1;
            #1;
            if (!rnd) begin
                check_eq(32'(o_if_de_ld), 1, "decode load while streaming");
            end
            if (o_wb_valid && i_wb_rdy) begin
                check_eq(32'(q_idx.size() > 0), 1, "writeback with empty model");
                k = q_idx.pop_front();
                c = q_cyc.pop_front();
                check_wb(k);
                if (check_lat) begin
                    check_eq(cyc - c, 3, "capture to writeback latency");
                end
                done++;
            end
            if (o_if_de_ld && i_fetch_valid) begin
                q_idx.push_back(idx);
                // decode captures on the coming rising edge
                q_cyc.push_back(cyc + 1);
                idx++;
            end
            cyc++;
        end
        check_eq(32'({o_exe_valid, o_mem_valid}), 0, "extra word in flight after stream");
        drain_pipe();
    endtask

    // cycle budget scales with the table
    initial begin
        wait (n_cases > 0);
        repeat (n_cases * 40) @(posedge i_clk);
        $display("timeout: the run did not finish within its cycle budget");
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        bit seen_wb;
        void'($urandom(32'h81e5));
        rst = 1'b1;
        i_instr = '0;
        i_fetch_valid = 1'b0;
        i_exe_rdy = 1'b1;
        i_mem_rdy = 1'b1;
        i_wb_rdy = 1'b1;

        add_case(op_lui, 3'd0, 7'h00, alu_add, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_u_imm);
        add_case(op_auipc, 3'd0, 7'h00, alu_add, alu1_pc, alu2_u_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_jal, 3'd0, 7'h00, alu_add, alu1_pc, alu2_j_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_pc_plus4);
        add_case(op_jalr, 3'd0, 7'h00, alu_add, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_pc_plus4);
        add_case(op_br, 3'd0, 7'h00, alu_add, alu1_pc, alu2_b_imm, cmp_beq, cmp_rs2, 0, 0, 0, rf_alu);
        add_case(op_br, 3'd1, 7'h00, alu_add, alu1_pc, alu2_b_imm, cmp_bne, cmp_rs2, 0, 0, 0, rf_alu);
        add_case(op_br, 3'd4, 7'h00, alu_add, alu1_pc, alu2_b_imm, cmp_blt, cmp_rs2, 0, 0, 0, rf_alu);
        add_case(op_br, 3'd5, 7'h00, alu_add, alu1_pc, alu2_b_imm, cmp_bge, cmp_rs2, 0, 0, 0, rf_alu);
        add_case(op_br, 3'd6, 7'h00, alu_add, alu1_pc, alu2_b_imm, cmp_bltu, cmp_rs2, 0, 0, 0, rf_alu);
        add_case(op_br, 3'd7, 7'h00, alu_add, alu1_pc, alu2_b_imm, cmp_bgeu, cmp_rs2, 0, 0, 0, rf_alu);
        add_case(op_load, 3'd0, 7'h00, alu_add, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 1, 0, 1, rf_lb);
        add_case(op_load, 3'd1, 7'h00, alu_add, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 1, 0, 1, rf_lh);
        add_case(op_load, 3'd2, 7'h00, alu_add, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 1, 0, 1, rf_lw);
        add_case(op_load, 3'd4, 7'h00, alu_add, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 1, 0, 1, rf_lbu);
        add_case(op_load, 3'd5, 7'h00, alu_add, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 1, 0, 1, rf_lhu);
        add_case(op_store, 3'd2, 7'h00, alu_add, alu1_rs1, alu2_s_imm, cmp_beq, cmp_rs2, 0, 1, 0, rf_alu);
        // immediate form, funct7 bit 5 only matters for shifts
        add_case(op_imm, 3'd0, 7'h00, alu_add, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_imm, 3'd0, 7'h20, alu_add, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_imm, 3'd1, 7'h00, alu_sll, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_imm, 3'd2, 7'h00, alu_add, alu1_rs1, alu2_i_imm, cmp_blt, cmp_i_imm, 0, 0, 1, rf_br_en);
        add_case(op_imm, 3'd3, 7'h00, alu_add, alu1_rs1, alu2_i_imm, cmp_bltu, cmp_i_imm, 0, 0, 1, rf_br_en);
        add_case(op_imm, 3'd4, 7'h00, alu_xor, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_imm, 3'd5, 7'h00, alu_srl, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_imm, 3'd5, 7'h20, alu_sra, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_imm, 3'd6, 7'h00, alu_or, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_imm, 3'd7, 7'h00, alu_and, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_reg, 3'd0, 7'h00, alu_add, alu1_rs1, alu2_rs2, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_reg, 3'd0, 7'h20, alu_sub, alu1_rs1, alu2_rs2, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_reg, 3'd1, 7'h00, alu_sll, alu1_rs1, alu2_rs2, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_reg, 3'd2, 7'h00, alu_add, alu1_rs1, alu2_rs2, cmp_blt, cmp_rs2, 0, 0, 1, rf_br_en);
        add_case(op_reg, 3'd3, 7'h00, alu_add, alu1_rs1, alu2_rs2, cmp_bltu, cmp_rs2, 0, 0, 1, rf_br_en);
        add_case(op_reg, 3'd4, 7'h00, alu_xor, alu1_rs1, alu2_rs2, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_reg, 3'd5, 7'h00, alu_srl, alu1_rs1, alu2_rs2, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_reg, 3'd5, 7'h20, alu_sra, alu1_rs1, alu2_rs2, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_reg, 3'd6, 7'h00, alu_or, alu1_rs1, alu2_rs2, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        add_case(op_reg, 3'd7, 7'h00, alu_and, alu1_rs1, alu2_rs2, cmp_beq, cmp_rs2, 0, 0, 1, rf_alu);
        // unknown opcode decodes as a no-op
        add_case(7'h7f, 3'd0, 7'h00, alu_add, alu1_rs1, alu2_i_imm, cmp_beq, cmp_rs2, 0, 0, 0, rf_alu);

        // reset: no loads while held
        repeat (4) begin
            @(negedge i_clk);
            check_loads(1'b0, "in reset");
            check_eq(32'({o_exe_mem_ld, o_mem_wb_ld}), 0, "later loads in reset");
        end
        rst = 1'b0;
        #1;
        check_eq(32'({o_exe_valid, o_mem_valid, o_wb_valid}), 0, "valids after reset");
        check_loads(1'b1, "after reset");
        check_eq(32'({o_exe_mem_ld, o_mem_wb_ld}), 3, "later loads after reset");

        // one instruction at a time through all stages
        for (int i = 0; i < n_cases; i++) begin
            send_one(i);
            seen_wb = 1'b0;
            while (!seen_wb) begin
                @(negedge i_clk);
                #1;
                if (o_exe_valid) begin
                    check_eq(32'({o_exe_aluop, o_exe_alu1_sel, o_exe_alu2_sel, o_exe_cmpop,
                                  o_exe_cmp_sel}), 32'(tbl_exe[i]),
                             $sformatf("exe word %0d", i));
                end
                if (o_mem_valid) begin
                    check_eq(32'({o_mem_read, o_mem_write}), 32'(tbl_mem[i]),
                             $sformatf("mem word %0d", i));
                end
                if (o_wb_valid) begin
                    check_wb(i);
                    seen_wb = 1'b1;
                end
            end
        end
        drain_pipe();

        run_stream(1'b0, 1'b1);

        // writeback stall freezes everything
        @(negedge i_clk);
        i_wb_rdy = 1'b0;
        send_one(2);
        while (!o_wb_valid) begin
            @(negedge i_clk);
            #1;
        end
        repeat (3) begin
            check_loads(1'b0, "writeback stall");
            check_eq(32'({o_exe_mem_ld, o_mem_wb_ld}), 0, "later loads in writeback stall");
            check_eq(32'({o_wb_valid, o_wb_ld_reg, o_wb_rf_sel, o_wb_rd}),
                     32'({1'b1, tbl_wb[2]}), "held writeback word");
            @(negedge i_clk);
            #1;
        end
        drain_pipe();

        // memory stall sends a bubble to writeback
        @(negedge i_clk);
        i_mem_rdy = 1'b0;
        send_one(12);
        while (!o_mem_valid) begin
            @(negedge i_clk);
            #1;
        end
        check_eq(32'(o_mem_wb_ld), 1, "mem_wb_ld in memory stall");
        check_eq(32'(o_exe_mem_ld), 0, "exe_mem_ld in memory stall");
        check_loads(1'b0, "memory stall");
        @(negedge i_clk);
        #1;
        check_eq(32'(o_wb_valid), 0, "bubble into writeback");
        drain_pipe();

        run_stream(1'b1, 1'b0);

        $display("Result: PASSED");
        $finish;
    end

endmodule
